// ==== verilog/bertPkg.sv ====
package bertPkg;

    //**************************************************
    // Bus and datapath widths
    //**************************************************
    localparam int REG_ADDR_W = 4;
    localparam int REG_DATA_W = 32;
    localparam int MUX_SEL_W  = 3;
    localparam int PN_ORDER   = 15;
    localparam int RATE_W     = 16;

    //**************************************************
    // Register map
    //**************************************************
    localparam logic [REG_ADDR_W-1:0] ADDR_VERSION     = 4'd0;
    localparam logic [REG_ADDR_W-1:0] ADDR_CONTROL     = 4'd1;
    localparam logic [REG_ADDR_W-1:0] ADDR_MUX_SELECT  = 4'd2;
    localparam logic [REG_ADDR_W-1:0] ADDR_PN_RATE     = 4'd3;
    localparam logic [REG_ADDR_W-1:0] ADDR_BERT_BITS   = 4'd4;
    localparam logic [REG_ADDR_W-1:0] ADDR_BERT_ERRORS = 4'd5;
    localparam logic [REG_ADDR_W-1:0] ADDR_BERT_STATUS = 4'd6;
    localparam logic [REG_ADDR_W-1:0] ADDR_COMMAND     = 4'd7;

    // Control register bits
    localparam int CTRL_PN_ENABLE_BIT   = 0;
    localparam int CTRL_BERT_ENABLE_BIT = 1;

    // Source select fields in the mux select register
    localparam int BERT_SRC_LSB = 0;
    localparam int OUT_SRC_LSB  = 4;

    // Command register bits, pulses only
    localparam int CMD_CLEAR_BIT  = 0;
    localparam int CMD_INJECT_BIT = 1;

    //**************************************************
    // Clock and data source codes
    //**************************************************
    // Codes 2 through 7 are idle inputs
    localparam logic [MUX_SEL_W-1:0] SRC_PN       = 3'd0;
    localparam logic [MUX_SEL_W-1:0] SRC_EXTERNAL = 3'd1;

endpackage

// ==== verilog/bertRegs.sv ====
`timescale 1ns/1ps

module bertRegs import bertPkg::*; #(
    parameter logic [REG_DATA_W-1:0] VersionNumber = 32'd429
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  regWrite,
    input  logic                  regRead,
    input  logic [REG_ADDR_W-1:0] regAddr,
    input  logic [REG_DATA_W-1:0] regWriteData,
    input  logic [REG_DATA_W-1:0] bitCount,
    input  logic [REG_DATA_W-1:0] errorCount,
    input  logic                  locked,
    output logic [REG_DATA_W-1:0] regReadData,
    output logic                  regReadValid,
    output logic                  pnEnable,
    output logic                  bertEnable,
    output logic [MUX_SEL_W-1:0]  bertSource,
    output logic [MUX_SEL_W-1:0]  outSource,
    output logic [RATE_W-1:0]     pnRate,
    output logic                  clearCounters,
    output logic                  injectError
);

    logic [REG_DATA_W-1:0] readMux;
    logic                  commandWrite;

    assign commandWrite = regWrite && (regAddr == ADDR_COMMAND);

    //**************************************************
    // Writable registers
    //**************************************************
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pnEnable   <= 1'b0;
            bertEnable <= 1'b0;
            bertSource <= SRC_PN;
            outSource  <= SRC_PN;
            pnRate     <= '0;
        end else if (regWrite) begin
            case (regAddr)
                ADDR_CONTROL: begin
                    pnEnable   <= regWriteData[CTRL_PN_ENABLE_BIT];
                    bertEnable <= regWriteData[CTRL_BERT_ENABLE_BIT];
                end
                ADDR_MUX_SELECT: begin
                    bertSource <= regWriteData[BERT_SRC_LSB +: MUX_SEL_W];
                    outSource  <= regWriteData[OUT_SRC_LSB +: MUX_SEL_W];
                end
                ADDR_PN_RATE: begin
                    pnRate <= regWriteData[RATE_W-1:0];
                end
                default: begin
                end
            endcase
        end
    end

    // Command strobes, high for one cycle per write
    always_ff @(posedge clk) begin
        if (!rstN) begin
            clearCounters <= 1'b0;
            injectError   <= 1'b0;
        end else begin
            clearCounters <= commandWrite && regWriteData[CMD_CLEAR_BIT];
            injectError   <= commandWrite && regWriteData[CMD_INJECT_BIT];
        end
    end

    //**************************************************
    // Read path
    //**************************************************
    always_comb begin
        readMux = '0;
        case (regAddr)
            ADDR_VERSION: begin
                readMux = VersionNumber;
            end
            ADDR_CONTROL: begin
                readMux[CTRL_PN_ENABLE_BIT]   = pnEnable;
                readMux[CTRL_BERT_ENABLE_BIT] = bertEnable;
            end
            ADDR_MUX_SELECT: begin
                readMux[BERT_SRC_LSB +: MUX_SEL_W] = bertSource;
                readMux[OUT_SRC_LSB +: MUX_SEL_W]  = outSource;
            end
            ADDR_PN_RATE: begin
                readMux[RATE_W-1:0] = pnRate;
            end
            ADDR_BERT_BITS: begin
                readMux = bitCount;
            end
            ADDR_BERT_ERRORS: begin
                readMux = errorCount;
            end
            ADDR_BERT_STATUS: begin
                readMux[0] = locked;
            end
            // Command and unmapped addresses read as zero
            default: begin
                readMux = '0;
            end
        endcase
    end

    // Fixed one-cycle read latency
    always_ff @(posedge clk) begin
        if (!rstN) begin
            regReadValid <= 1'b0;
        end else begin
            regReadValid <= regRead;
        end
    end

    always_ff @(posedge clk) begin
        if (regRead) begin
            regReadData <= readMux;
        end
    end

    // Bus master never issues a read and a write together
    assert property (@(posedge clk) disable iff (!rstN) !(regRead && regWrite))
        else $error("bertRegs: read and write in the same cycle");

endmodule

// ==== verilog/clockDataMux.sv ====
`timescale 1ns/1ps

module clockDataMux import bertPkg::*; (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic [MUX_SEL_W-1:0]      select,
    input  logic [2**MUX_SEL_W-1:0]   clkEnIn,
    input  logic [2**MUX_SEL_W-1:0]   dataIn,
    output logic                      clkEnOut,
    output logic                      dataOut
);

    //**************************************************
    // Registered source selection
    //**************************************************
    // Strobe is control, cleared by reset
    always_ff @(posedge clk) begin
        if (!rstN) begin
            clkEnOut <= 1'b0;
        end else begin
            clkEnOut <= clkEnIn[select];
        end
    end

    // Data bit follows the strobe by the same single cycle
    always_ff @(posedge clk) begin
        dataOut <= dataIn[select];
    end

    // Idle sources are tied off at the top level, so they never strobe
    assert property (@(posedge clk) disable iff (!rstN)
        (select > SRC_EXTERNAL) |=> !clkEnOut)
        else $error("clockDataMux: strobe from an idle source");

endmodule

// ==== verilog/pnGenerator.sv ====
`timescale 1ns/1ps

module pnGenerator import bertPkg::*; (
    input  logic              clk,
    input  logic              rstN,
    input  logic              enable,
    input  logic [RATE_W-1:0] rate,
    input  logic              injectError,
    output logic              pnClkEn,
    output logic              pnBit
);

    logic [RATE_W-1:0] divCount;
    logic [PN_ORDER:1] pnReg;
    logic              injectPending;
    logic              strobe;
    logic              feedback;

    // One strobe every rate+1 cycles
    assign strobe   = enable && (divCount == rate);
    // x^15 + x^14 + 1
    assign feedback = pnReg[PN_ORDER] ^ pnReg[PN_ORDER-1];

    //**************************************************
    // Bit rate divider
    //**************************************************
    always_ff @(posedge clk) begin
        if (!rstN || !enable) begin
            divCount <= '0;
        end else if (strobe) begin
            divCount <= '0;
        end else begin
            divCount <= divCount + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pnClkEn <= 1'b0;
        end else begin
            pnClkEn <= strobe;
        end
    end

    //**************************************************
    // PN15 shift register
    //**************************************************
    // Reload the all-ones seed whenever stopped
    always_ff @(posedge clk) begin
        if (!rstN || !enable) begin
            pnReg <= '1;
        end else if (strobe) begin
            pnReg <= {pnReg[PN_ORDER-1:1], feedback};
        end
    end

    // Injection only flips the emitted bit, not the register
    always_ff @(posedge clk) begin
        if (!rstN || !enable) begin
            injectPending <= 1'b0;
        end else if (strobe) begin
            injectPending <= 1'b0;
        end else if (injectError) begin
            injectPending <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (strobe) begin
            pnBit <= feedback ^ (injectPending | injectError);
        end
    end

endmodule

// ==== verilog/bertChecker.sv ====
`timescale 1ns/1ps

module bertChecker import bertPkg::*; #(
    parameter int LockCount  = 32,
    parameter int LossWindow = 64,
    parameter int LossErrors = 8
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  enable,
    input  logic                  clkEn,
    input  logic                  data,
    input  logic                  clearCounters,
    output logic                  locked,
    output logic [REG_DATA_W-1:0] bitCount,
    output logic [REG_DATA_W-1:0] errorCount
);

    localparam int MatchW   = $clog2(LockCount + 1);
    localparam int WinBitsW = $clog2(LossWindow + 1);
    localparam int WinErrW  = $clog2(LossErrors + 1);

    logic [PN_ORDER:1]    history;
    logic                 predicted;
    logic                 mismatch;
    logic                 countBit;
    logic [MatchW-1:0]    matchCount;
    logic [WinBitsW-1:0]  windowBits;
    logic [WinErrW-1:0]   windowErrors;

    // Prediction from received bits, so a channel error shows up three times
    assign predicted = history[PN_ORDER] ^ history[PN_ORDER-1];
    assign mismatch  = data ^ predicted;
    assign countBit  = enable && locked && clkEn;

    //**************************************************
    // Received bit history
    //**************************************************
    always_ff @(posedge clk) begin
        if (clkEn) begin
            history <= {history[PN_ORDER-1:1], data};
        end
    end

    //**************************************************
    // Lock acquisition and loss
    //**************************************************
    always_ff @(posedge clk) begin
        if (!rstN || !enable) begin
            locked       <= 1'b0;
            matchCount   <= '0;
            windowBits   <= '0;
            windowErrors <= '0;
        end else if (clkEn) begin
            if (!locked) begin
                // Searching for a run of matches
                if (mismatch) begin
                    matchCount <= '0;
                end else if (matchCount == MatchW'(LockCount - 1)) begin
                    locked       <= 1'b1;
                    matchCount   <= '0;
                    windowBits   <= '0;
                    windowErrors <= '0;
                end else begin
                    matchCount <= matchCount + 1'b1;
                end
            end else begin
                // Too many errors in one window drops lock
                if (mismatch && (windowErrors == WinErrW'(LossErrors - 1))) begin
                    locked       <= 1'b0;
                    windowBits   <= '0;
                    windowErrors <= '0;
                end else if (windowBits == WinBitsW'(LossWindow - 1)) begin
                    windowBits   <= '0;
                    windowErrors <= '0;
                end else begin
                    windowBits <= windowBits + 1'b1;
                    if (mismatch) begin
                        windowErrors <= windowErrors + 1'b1;
                    end
                end
            end
        end
    end

    //**************************************************
    // Bit and error counters
    //**************************************************
    // Both saturate at all ones
    always_ff @(posedge clk) begin
        if (!rstN || clearCounters) begin
            bitCount   <= '0;
            errorCount <= '0;
        end else if (countBit) begin
            if (bitCount != '1) begin
                bitCount <= bitCount + 1'b1;
            end
            if (mismatch && (errorCount != '1)) begin
                errorCount <= errorCount + 1'b1;
            end
        end
    end

    // Every counted error was also a counted bit
    assert property (@(posedge clk) disable iff (!rstN) errorCount <= bitCount)
        else $error("bertChecker: error count above bit count");

endmodule

// ==== verilog/bitsyncBertTop.sv ====
`timescale 1ns/1ps

module bitsyncBertTop import bertPkg::*; #(
    parameter logic [REG_DATA_W-1:0] VersionNumber = 32'd429,
    parameter int                    LockCount     = 32,
    parameter int                    LossWindow    = 64,
    parameter int                    LossErrors    = 8
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  regWrite,
    input  logic                  regRead,
    input  logic [REG_ADDR_W-1:0] regAddr,
    input  logic [REG_DATA_W-1:0] regWriteData,
    input  logic                  extClkEn,
    input  logic                  extData,
    output logic [REG_DATA_W-1:0] regReadData,
    output logic                  regReadValid,
    output logic                  serialClkEn,
    output logic                  serialData,
    output logic                  lockN
);

    logic                  pnEnable;
    logic                  bertEnable;
    logic [MUX_SEL_W-1:0]  bertSource;
    logic [MUX_SEL_W-1:0]  outSource;
    logic [RATE_W-1:0]     pnRate;
    logic                  clearCounters;
    logic                  injectError;
    logic                  pnClkEn;
    logic                  pnBit;
    logic                  bertClkEn;
    logic                  bertData;
    logic                  locked;
    logic [REG_DATA_W-1:0] bitCount;
    logic [REG_DATA_W-1:0] errorCount;

    //**************************************************
    // Control registers
    //**************************************************
    bertRegs #(.VersionNumber(VersionNumber)) regs (
        .clk(clk), .rstN(rstN),
        .regWrite(regWrite), .regRead(regRead),
        .regAddr(regAddr), .regWriteData(regWriteData),
        .bitCount(bitCount), .errorCount(errorCount), .locked(locked),
        .regReadData(regReadData), .regReadValid(regReadValid),
        .pnEnable(pnEnable), .bertEnable(bertEnable),
        .bertSource(bertSource), .outSource(outSource), .pnRate(pnRate),
        .clearCounters(clearCounters), .injectError(injectError)
    );

    pnGenerator pnGen (
        .clk(clk), .rstN(rstN), .enable(pnEnable), .rate(pnRate),
        .injectError(injectError), .pnClkEn(pnClkEn), .pnBit(pnBit)
    );

    //**************************************************
    // Source selection with idle codes tied low
    //**************************************************
    clockDataMux bertSelect (
        .clk(clk), .rstN(rstN), .select(bertSource),
        .clkEnIn({6'b0, extClkEn, pnClkEn}), .dataIn({6'b0, extData, pnBit}),
        .clkEnOut(bertClkEn), .dataOut(bertData)
    );

    clockDataMux outSelect (
        .clk(clk), .rstN(rstN), .select(outSource),
        .clkEnIn({6'b0, extClkEn, pnClkEn}), .dataIn({6'b0, extData, pnBit}),
        .clkEnOut(serialClkEn), .dataOut(serialData)
    );

    bertChecker #(
        .LockCount(LockCount), .LossWindow(LossWindow), .LossErrors(LossErrors)
    ) bertCheck (
        .clk(clk), .rstN(rstN), .enable(bertEnable),
        .clkEn(bertClkEn), .data(bertData), .clearCounters(clearCounters),
        .locked(locked), .bitCount(bitCount), .errorCount(errorCount)
    );

    // Lock LED is active low
    assign lockN = !locked;

endmodule

// ==== testbench/tbBitsyncBert.sv ====
`timescale 1ns/1ps

module tbBitsyncBert import bertPkg::*; ();

    localparam logic [31:0] VersionExpected = 32'd429;
    localparam int          LockBitsMax     = 32 + 40;
    localparam int          PnCheckBits     = 200;
    localparam int          TimeoutCycles   = 60000;

    logic                  clk;
    logic                  rstN;
    logic                  regWrite;
    logic                  regRead;
    logic [REG_ADDR_W-1:0] regAddr;
    logic [REG_DATA_W-1:0] regWriteData;
    logic                  extClkEn;
    logic                  extData;
    logic [REG_DATA_W-1:0] regReadData;
    logic                  regReadValid;
    logic                  serialClkEn;
    logic                  serialData;
    logic                  lockN;

    int          errCount;
    int          cycleCount;
    int          lastStrobeCycle;
    int          pnIndex;
    logic        pnCheckOn;
    logic        extCheckOn;
    int          extQueue[$];
    string       testName;
    logic [31:0] rngState;

    bitsyncBertTop i_dut (
        .clk(clk), .rstN(rstN),
        .regWrite(regWrite), .regRead(regRead),
        .regAddr(regAddr), .regWriteData(regWriteData),
        .extClkEn(extClkEn), .extData(extData),
        .regReadData(regReadData), .regReadValid(regReadValid),
        .serialClkEn(serialClkEn), .serialData(serialData), .lockN(lockN)
    );

    always #5 clk = ~clk;

    //**************************************************
    // Reference models
    //**************************************************
    // PN15 bit number index, x^15 + x^14 + 1 from the all-ones seed
    function automatic logic pnRefBit(input int index);
        logic [15:1] state;
        logic        newBit;
        state  = '1;
        newBit = 1'b0;
        for (int i = 0; i <= index; i++) begin
            newBit = state[15] ^ state[14];
            state  = {state[14:1], newBit};
        end
        return newBit;
    endfunction

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic reportMismatch(input string what, input logic [31:0] expected,
                                  input logic [31:0] actual);
        errCount++;
        $display("ERROR [%s] %s: expected 0x%0h, got 0x%0h", testName, what, expected, actual);
    endtask

    //**************************************************
    // Register bus
    //**************************************************
    task automatic regWriteTask(input logic [REG_ADDR_W-1:0] addr, input logic [31:0] data);
        @(posedge clk);
        #1;
        regWrite     = 1'b1;
        regAddr      = addr;
        regWriteData = data;
        @(posedge clk);
        #1;
        regWrite = 1'b0;
    endtask

    // Valid must be high exactly one cycle after the read strobe
    task automatic regReadTask(input logic [REG_ADDR_W-1:0] addr, output logic [31:0] data);
        @(posedge clk);
        #1;
        regRead = 1'b1;
        regAddr = addr;
        @(posedge clk);
        #1;
        regRead = 1'b0;
        if (regReadValid !== 1'b1) begin
            reportMismatch("regReadValid one cycle after read", 1, regReadValid);
        end
        data = regReadData;
        @(posedge clk);
        #1;
        if (regReadValid !== 1'b0) begin
            reportMismatch("regReadValid after read", 0, regReadValid);
        end
    endtask

    task automatic waitSerialBits(input int count);
        int seen;
        seen = 0;
        while (seen < count) begin
            @(negedge clk);
            if (serialClkEn) begin
                seen++;
            end
        end
    endtask

    //**************************************************
    // Output stream compare and timeout
    //**************************************************
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            $display("Timeout after %0d cycles while running %s", cycleCount, testName);
            $display("Simulation FAILED");
            $finish;
        end
    end

    always @(negedge clk) begin
        int tag;
        if (serialClkEn && pnCheckOn) begin
            if (pnIndex > 0 && (cycleCount - lastStrobeCycle) != 4) begin
                reportMismatch("serialClkEn spacing", 4, cycleCount - lastStrobeCycle);
            end
            if (serialData !== pnRefBit(pnIndex)) begin
                reportMismatch($sformatf("PN bit %0d", pnIndex), pnRefBit(pnIndex), serialData);
            end
            lastStrobeCycle = cycleCount;
            pnIndex++;
            if (pnIndex >= PnCheckBits) begin
                pnCheckOn = 1'b0;
            end
        end
        if (serialClkEn && extCheckOn) begin
            if (extQueue.size() == 0) begin
                errCount++;
                $display("[%s] serial strobe with no external bit driven", testName);
            end else begin
                tag = extQueue.pop_front();
                if ((tag / 2) + 1 != cycleCount) begin
                    reportMismatch("external bit latency", 1, cycleCount - tag / 2);
                end
                if (serialData !== tag[0]) begin
                    reportMismatch("external bit", tag[0], serialData);
                end
            end
        end
    end

    //**************************************************
    // Test sequence
    //**************************************************
    initial begin
        logic [31:0] readValue;
        int          bitsSeen;
        clk = 1'b0;
        rstN = 1'b0;
        regWrite = 1'b0;
        regRead = 1'b0;
        regAddr = '0;
        regWriteData = '0;
        extClkEn = 1'b0;
        extData = 1'b0;
        errCount = 0;
        cycleCount = 0;
        lastStrobeCycle = 0;
        pnIndex = 0;
        pnCheckOn = 1'b0;
        extCheckOn = 1'b0;
        rngState = 32'd20329;
        testName = "reset";
        repeat (10) @(posedge clk);
        #1;
        rstN = 1'b1;

        // Quiet outputs after reset
        repeat (8) begin
            @(negedge clk);
            if (serialClkEn !== 1'b0) reportMismatch("serialClkEn", 0, serialClkEn);
            if (lockN !== 1'b1) reportMismatch("lockN", 1, lockN);
        end
        regReadTask(ADDR_VERSION, readValue);
        if (readValue !== VersionExpected) reportMismatch("version", VersionExpected, readValue);

        testName = "readback";
        regWriteTask(ADDR_CONTROL, 32'h2);
        regWriteTask(ADDR_MUX_SELECT, 32'h53);
        regWriteTask(ADDR_PN_RATE, 32'hBEEF);
        regReadTask(ADDR_CONTROL, readValue);
        if (readValue !== 32'h2) reportMismatch("control", 32'h2, readValue);
        regReadTask(ADDR_MUX_SELECT, readValue);
        if (readValue !== 32'h53) reportMismatch("mux select", 32'h53, readValue);
        regReadTask(ADDR_PN_RATE, readValue);
        if (readValue !== 32'hBEEF) reportMismatch("pn rate", 32'hBEEF, readValue);
        regReadTask(ADDR_COMMAND, readValue);
        if (readValue !== 32'h0) reportMismatch("command", 0, readValue);
        regWriteTask(ADDR_CONTROL, 32'h0);

        testName = "pn output";
        regWriteTask(ADDR_PN_RATE, 32'd3);
        regWriteTask(ADDR_MUX_SELECT, 32'h00);
        pnIndex = 0;
        pnCheckOn = 1'b1;
        regWriteTask(ADDR_CONTROL, 32'h1);
        while (pnCheckOn) @(negedge clk);

        testName = "lock";
        regWriteTask(ADDR_CONTROL, 32'h3);
        bitsSeen = 0;
        while (lockN && bitsSeen < LockBitsMax) begin
            @(negedge clk);
            if (serialClkEn) bitsSeen++;
        end
        if (lockN) begin
            errCount++;
            $display("[%s] checker did not lock within %0d bits", testName, LockBitsMax);
        end
        regWriteTask(ADDR_COMMAND, 32'h1 << CMD_CLEAR_BIT);
        waitSerialBits(500);
        regReadTask(ADDR_BERT_ERRORS, readValue);
        if (readValue !== 32'd0) reportMismatch("clean error count", 0, readValue);
        regReadTask(ADDR_BERT_BITS, readValue);
        if (readValue < 32'd400) reportMismatch("bit count at least 400", 400, readValue);

        // Each channel error shows up three times in the checker
        testName = "injection";
        regWriteTask(ADDR_COMMAND, 32'h1 << CMD_CLEAR_BIT);
        repeat (5) begin
            waitSerialBits(10);
            regWriteTask(ADDR_COMMAND, 32'h1 << CMD_INJECT_BIT);
            waitSerialBits(50);
        end
        regReadTask(ADDR_BERT_ERRORS, readValue);
        if (readValue !== 32'd15) reportMismatch("error count", 15, readValue);
        regReadTask(ADDR_BERT_STATUS, readValue);
        if (readValue !== 32'd1) reportMismatch("lock status", 1, readValue);
        if (lockN !== 1'b0) reportMismatch("lockN", 0, lockN);

        testName = "external";
        regWriteTask(ADDR_CONTROL, 32'h1 << CTRL_BERT_ENABLE_BIT);
        regWriteTask(ADDR_MUX_SELECT, (SRC_EXTERNAL << OUT_SRC_LSB) | SRC_EXTERNAL);
        extCheckOn = 1'b1;
        repeat (300) begin
            @(posedge clk);
            #1;
            rngState = xorshift(rngState);
            extClkEn = 1'b1;
            extData = rngState[0];
            extQueue.push_back(cycleCount * 2 + rngState[0]);
        end
        @(posedge clk);
        #1;
        extClkEn = 1'b0;
        repeat (4) @(posedge clk);
        if (extQueue.size() != 0) begin
            errCount++;
            $display("[%s] %0d external bits never reached the output", testName,
                     extQueue.size());
        end
        if (lockN !== 1'b1) reportMismatch("lockN on random data", 1, lockN);

        $display("Run complete, %0d errors", errCount);
        if (errCount == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== files.f ====
verilog/bertPkg.sv
verilog/bertRegs.sv
verilog/clockDataMux.sv
verilog/pnGenerator.sv
verilog/bertChecker.sv
verilog/bitsyncBertTop.sv
testbench/tbBitsyncBert.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module tbBitsyncBert -o simv
output=$(./obj_dir/simv)
echo "$output"
if echo "$output" | grep -q "Simulation PASSED"; then
    exit 0
fi
exit 1
